// ==== hdl/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // board side joystick word
    localparam int BOARD_JOY_W = 16;
    localparam int DIR_W       = 4;                     // up, down, left, right
    localparam int BTN_W       = BOARD_JOY_W - DIR_W;   // buttons above the nibble

    // game side
    localparam int GAME_JOY_W  = 10;
    localparam int NUM_PLAYERS = 4;
    localparam int GFX_LAYERS  = 4;

    // game reset stretch counter
    localparam int RST_CNT_W   = 8;

    // one board joystick word, seen either whole or split into
    // buttons and direction nibble
    typedef union packed {
        logic [BOARD_JOY_W-1:0] raw;
        struct packed {
            logic [BTN_W-1:0] buttons;
            logic [DIR_W-1:0] dir;
        } fields;
    } board_joy_u;

endpackage

`default_nettype wire

// ==== hdl/joy_4way.sv ====
`timescale 1ns/100ps
`default_nettype none

module joy_4way import board_pkg::*; (
    input  logic             clk_sys,
    input  logic             rst,
    input  logic             enable,    // restrict to four-way movement
    input  logic [DIR_W-1:0] joy8way,
    output logic [DIR_W-1:0] joy4way
);

    logic at_most_one;   // zero or one direction pressed

    // clearing the lowest set bit leaves nothing when only one was set
    assign at_most_one = (joy8way & (joy8way - 1'b1)) == '0;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy4way <= '0;
        end else if (!enable) begin
            joy4way <= joy8way;          // plain eight-way
        end else if (at_most_one) begin
            joy4way <= joy8way;
        end
        // diagonals keep the last accepted direction
    end

    // a diagonal may still be held in the cycle after enable rises
    a_four_way_only: assert property (
        @(posedge clk_sys) disable iff (rst)
        $past(enable) |-> $onehot0(joy4way)
    ) else $error("joy_4way: more than one direction with four-way enabled");

endmodule

`default_nettype wire

// ==== hdl/joy_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module joy_capture import board_pkg::*; #(
    parameter int BUTTONS = 2
) (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       en4way,
    input  board_joy_u board_joy1,
    input  board_joy_u board_joy2,
    input  board_joy_u board_joy3,
    input  board_joy_u board_joy4,
    output board_joy_u joy1_sync,
    output board_joy_u joy2_sync,
    output board_joy_u joy3_sync,
    output board_joy_u joy4_sync,
    output logic       joy_pause    // pause button of player 1 or 2
);

    localparam int PAUSE_BIT = BUTTONS + 6;

    board_joy_u       board_w [NUM_PLAYERS];
    board_joy_u       sync_q  [NUM_PLAYERS];
    logic [DIR_W-1:0] dir_4w  [NUM_PLAYERS];

    assign board_w[0] = board_joy1;
    assign board_w[1] = board_joy2;
    assign board_w[2] = board_joy3;
    assign board_w[3] = board_joy4;

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        joy_4way u_4way (
            .clk_sys (clk_sys),
            .rst     (rst),
            .enable  (en4way),
            .joy8way (board_w[p].fields.dir),
            .joy4way (dir_4w[p])
        );

        // buttons one cycle, directions two
        always_ff @(posedge clk_sys) begin
            sync_q[p].raw <= {board_w[p].fields.buttons, dir_4w[p]};
        end
    end

    assign joy1_sync = sync_q[0];
    assign joy2_sync = sync_q[1];
    assign joy3_sync = sync_q[2];
    assign joy4_sync = sync_q[3];

    assign joy_pause = sync_q[0].raw[PAUSE_BIT] | sync_q[1].raw[PAUSE_BIT];

endmodule

`default_nettype wire

// ==== hdl/joy_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module joy_mapper import board_pkg::*; #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   rot_control,   // vertical game on a horizontal screen
    input  board_joy_u             joy1_sync,
    input  board_joy_u             joy2_sync,
    input  board_joy_u             joy3_sync,
    input  board_joy_u             joy4_sync,
    output logic [GAME_JOY_W-1:0]  game_joystick1,
    output logic [GAME_JOY_W-1:0]  game_joystick2,
    output logic [GAME_JOY_W-1:0]  game_joystick3,
    output logic [GAME_JOY_W-1:0]  game_joystick4,
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start
);

    localparam int START_BIT = BUTTONS + 4;
    localparam int COIN_BIT  = BUTTONS + 5;

    board_joy_u            sync_w [NUM_PLAYERS];
    logic [GAME_JOY_W-1:0] joy_q  [NUM_PLAYERS];

    // low bits of the word, direction nibble turned a quarter when rot is set
    function automatic logic [GAME_JOY_W-1:0] map_joy(
        input board_joy_u j,
        input logic       rot
    );
        logic [DIR_W-1:0] d;
        d = j.fields.dir;
        if (rot) begin
            d = {j.fields.dir[0], j.fields.dir[1], j.fields.dir[3], j.fields.dir[2]};
        end
        return {GAME_JOY_W{ACTIVE_LOW}} ^ {j.fields.buttons[GAME_JOY_W-DIR_W-1:0], d};
    endfunction

    assign sync_w[0] = joy1_sync;
    assign sync_w[1] = joy2_sync;
    assign sync_w[2] = joy3_sync;
    assign sync_w[3] = joy4_sync;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                joy_q[p] <= {GAME_JOY_W{ACTIVE_LOW}};   // nothing pressed
            end
            game_coin  <= {NUM_PLAYERS{ACTIVE_LOW}};
            game_start <= {NUM_PLAYERS{ACTIVE_LOW}};
        end else begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                joy_q[p]      <= map_joy(sync_w[p], rot_control);
                game_coin[p]  <= sync_w[p].raw[COIN_BIT] ^ ACTIVE_LOW;
                game_start[p] <= sync_w[p].raw[START_BIT] ^ ACTIVE_LOW;
            end
        end
    end

    assign game_joystick1 = joy_q[0];
    assign game_joystick2 = joy_q[1];
    assign game_joystick3 = joy_q[2];
    assign game_joystick4 = joy_q[3];

endmodule

`default_nettype wire

// ==== hdl/board_control.sv ====
`timescale 1ns/100ps
`default_nettype none

module board_control import board_pkg::*; #(
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  key_pause,
    input  logic                  key_reset,
    input  logic                  key_service,
    input  logic [GFX_LAYERS-1:0] key_gfx,
    input  logic                  osd_pause,     // toggles on every high cycle
    input  logic                  joy_pause,
    input  logic                  downloading,
    output logic                  game_pause,
    output logic                  soft_rst,      // single cycle
    output logic [GFX_LAYERS-1:0] gfx_en,
    output logic                  game_service
);

    logic                  last_key_pause;
    logic                  last_joy_pause;
    logic                  last_key_reset;
    logic [GFX_LAYERS-1:0] last_gfx;

    logic                  pause_toggle;
    logic                  reset_rise;
    logic [GFX_LAYERS-1:0] gfx_rise;

    // previous samples for the edge detectors
    always_ff @(posedge clk_sys) begin
        last_key_pause <= key_pause;
        last_joy_pause <= joy_pause;
        last_key_reset <= key_reset;
        last_gfx       <= key_gfx;
    end

    assign pause_toggle = (key_pause & ~last_key_pause)
                        | (joy_pause & ~last_joy_pause)
                        | osd_pause;
    assign reset_rise   = key_reset & ~last_key_reset;
    assign gfx_rise     = key_gfx & ~last_gfx;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause   <= 1'b0;
            soft_rst     <= 1'b0;
            gfx_en       <= '1;            // all layers on
            game_service <= ACTIVE_LOW;
        end else begin
            soft_rst <= reset_rise;
            if (downloading) begin
                game_pause <= 1'b0;        // no pause while loading
            end else if (pause_toggle) begin
                game_pause <= ~game_pause;
            end
            gfx_en       <= gfx_en ^ gfx_rise;   // per layer toggle
            game_service <= key_service ^ ACTIVE_LOW;
        end
    end

    a_soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst
    ) else $error("board_control: soft_rst high for more than one cycle");

endmodule

`default_nettype wire

// ==== hdl/reset_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module reset_gen import board_pkg::*; #(
    parameter int RST_HOLD = 255   // extra cycles after the last cause
) (
    input  logic clk_sys,
    input  logic rst,
    input  logic downloading,
    input  logic rst_req,
    input  logic soft_rst,
    output logic game_rst
);

    localparam logic [RST_CNT_W-1:0] HOLD = RST_CNT_W'(RST_HOLD);

    logic [RST_CNT_W-1:0] cnt;
    logic                 cause;

    assign cause = rst | downloading | rst_req | soft_rst;

    always_ff @(posedge clk_sys) begin
        if (cause) begin
            cnt      <= '0;       // restart the stretch
            game_rst <= 1'b1;
        end else if (cnt != HOLD) begin
            cnt      <= cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;     // stretch done
        end
    end

    a_rst_to_game: assert property (
        @(posedge clk_sys)
        rst |=> game_rst
    ) else $error("reset_gen: game_rst low right after rst");

endmodule

`default_nettype wire

// ==== hdl/board_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module board_top import board_pkg::*; #(
    parameter int BUTTONS    = 2,      // game buttons, 2 to 9
    parameter bit ACTIVE_LOW = 1'b1    // game inputs inverted
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    // board joysticks, active high
    input  logic [BOARD_JOY_W-1:0] board_joy1,
    input  logic [BOARD_JOY_W-1:0] board_joy2,
    input  logic [BOARD_JOY_W-1:0] board_joy3,
    input  logic [BOARD_JOY_W-1:0] board_joy4,
    input  logic                   en4way,
    input  logic                   rot_control,
    input  logic                   key_pause,
    input  logic                   key_reset,
    input  logic                   key_service,
    input  logic [GFX_LAYERS-1:0]  key_gfx,
    input  logic                   osd_pause,
    input  logic                   downloading,
    input  logic                   rst_req,
    // game side
    output logic [GAME_JOY_W-1:0]  game_joystick1,
    output logic [GAME_JOY_W-1:0]  game_joystick2,
    output logic [GAME_JOY_W-1:0]  game_joystick3,
    output logic [GAME_JOY_W-1:0]  game_joystick4,
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start,
    output logic                   game_service,
    output logic                   game_pause,
    output logic [GFX_LAYERS-1:0]  gfx_en,
    output logic                   game_rst
);

    board_joy_u joy1_sync;
    board_joy_u joy2_sync;
    board_joy_u joy3_sync;
    board_joy_u joy4_sync;
    logic       joy_pause;
    logic       soft_rst;

    joy_capture #(
        .BUTTONS (BUTTONS)
    ) u_capture (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .en4way     (en4way),
        .board_joy1 (board_joy1),
        .board_joy2 (board_joy2),
        .board_joy3 (board_joy3),
        .board_joy4 (board_joy4),
        .joy1_sync  (joy1_sync),
        .joy2_sync  (joy2_sync),
        .joy3_sync  (joy3_sync),
        .joy4_sync  (joy4_sync),
        .joy_pause  (joy_pause)
    );

    joy_mapper #(
        .BUTTONS    (BUTTONS),
        .ACTIVE_LOW (ACTIVE_LOW)
    ) u_mapper (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .rot_control    (rot_control),
        .joy1_sync      (joy1_sync),
        .joy2_sync      (joy2_sync),
        .joy3_sync      (joy3_sync),
        .joy4_sync      (joy4_sync),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_joystick3 (game_joystick3),
        .game_joystick4 (game_joystick4),
        .game_coin      (game_coin),
        .game_start     (game_start)
    );

    board_control #(
        .ACTIVE_LOW (ACTIVE_LOW)
    ) u_control (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .key_pause    (key_pause),
        .key_reset    (key_reset),
        .key_service  (key_service),
        .key_gfx      (key_gfx),
        .osd_pause    (osd_pause),
        .joy_pause    (joy_pause),
        .downloading  (downloading),
        .game_pause   (game_pause),
        .soft_rst     (soft_rst),
        .gfx_en       (gfx_en),
        .game_service (game_service)
    );

    reset_gen u_reset (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .downloading (downloading),
        .rst_req     (rst_req),
        .soft_rst    (soft_rst),
        .game_rst    (game_rst)
    );

endmodule

`default_nettype wire

// ==== bench/board_model.svh ====
`ifndef BOARD_MODEL_SVH
`define BOARD_MODEL_SVH

// expected game side values, included in board_tb where BUTTONS and
// ACTIVE_LOW are visible

// four-way rule, a diagonal leaves the last accepted direction
function automatic logic [3:0] filter_dir(input logic [3:0] dir, input logic [3:0] held,
                                          input logic four_way);
    if (four_way && $countones(dir) > 1) begin
        return held;
    end
    return dir;
endfunction

function automatic logic [9:0] expect_joy(input logic [15:0] word, input logic [3:0] held,
                                          input logic four_way, input logic rot);
    logic [3:0] d;
    logic [3:0] turned;
    logic [9:0] game;
    d = filter_dir(word[3:0], held, four_way);
    turned[3] = d[0];   // quarter turn of the stick
    turned[2] = d[1];
    turned[1] = d[3];
    turned[0] = d[2];
    game = {word[9:4], rot ? turned : d};
    return ACTIVE_LOW ? ~game : game;
endfunction

// bit n belongs to player n+1
function automatic logic [3:0] expect_coin(input logic [63:0] words);
    logic [3:0] c;
    int         n;
    for (n = 0; n < 4; n++) begin
        c[n] = words[16*n + BUTTONS + 5];
    end
    return ACTIVE_LOW ? ~c : c;
endfunction

function automatic logic [3:0] expect_start(input logic [63:0] words);
    logic [3:0] s;
    int         n;
    for (n = 0; n < 4; n++) begin
        s[n] = words[16*n + BUTTONS + 4];
    end
    return ACTIVE_LOW ? ~s : s;
endfunction

`endif

// ==== bench/board_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module board_tb;

    localparam int BUTTONS    = 2;
    localparam bit ACTIVE_LOW = 1'b1;
    localparam int PAUSE_BIT  = BUTTONS + 6;

    logic        clk_sys;
    logic        rst;
    logic [15:0] board_joy1, board_joy2, board_joy3, board_joy4;
    logic        en4way, rot_control, key_pause, key_reset, key_service;
    logic        osd_pause, downloading, rst_req;
    logic [3:0]  key_gfx;
    logic [9:0]  game_joystick1, game_joystick2, game_joystick3, game_joystick4;
    logic [3:0]  game_coin, game_start, gfx_en;
    logic        game_service, game_pause, game_rst;

    integer      seed;
    int          errors;
    int          checks;
    int          test_errors;
    int          i;
    int          p;
    int          cycles;
    logic [63:0] words;
    logic        cmp_joy;     // comparison window open
    logic [9:0]  exp_joy [4];
    logic [3:0]  exp_coin, exp_start;
    logic [3:0]  held_dir [4];
    logic        jp_prev;     // pause bits of players 1 and 2, last vector
    logic        exp_pause;
    logic [3:0]  exp_gfx;

    `include "board_model.svh"

    board_top #(
        .BUTTONS    (BUTTONS),
        .ACTIVE_LOW (ACTIVE_LOW)
    ) DUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch %s: got %h, expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s, %0d errors", name,
                 (errors == test_errors) ? "passed" : "FAILED", errors - test_errors);
        test_errors = errors;
    endtask

    // joystick outputs against the model while the window is open
    always @(posedge clk_sys) begin
        if (cmp_joy) begin
            check_value("game_joystick1", 32'(game_joystick1), 32'(exp_joy[0]));
            check_value("game_joystick2", 32'(game_joystick2), 32'(exp_joy[1]));
            check_value("game_joystick3", 32'(game_joystick3), 32'(exp_joy[2]));
            check_value("game_joystick4", 32'(game_joystick4), 32'(exp_joy[3]));
            check_value("game_coin", 32'(game_coin), 32'(exp_coin));
            check_value("game_start", 32'(game_start), 32'(exp_start));
        end
    end

    // one board vector held for 6 cycles, last two of them compared
    task automatic apply_vector(input logic [63:0] w, input logic rot, input logic four_way);
        int   n;
        logic jp;
        @(posedge clk_sys);
        board_joy1  <= w[15:0];
        board_joy2  <= w[31:16];
        board_joy3  <= w[47:32];
        board_joy4  <= w[63:48];
        rot_control <= rot;
        en4way      <= four_way;
        cmp_joy     <= 1'b0;
        for (n = 0; n < 4; n++) begin
            exp_joy[n] <= expect_joy(w[16*n +: 16], held_dir[n], four_way, rot);
            held_dir[n] = filter_dir(w[16*n +: 4], held_dir[n], four_way);
        end
        exp_coin  <= expect_coin(w);
        exp_start <= expect_start(w);
        jp = w[PAUSE_BIT] | w[16 + PAUSE_BIT];
        if (jp && !jp_prev) begin
            exp_pause = ~exp_pause;   // joystick pause button press
        end
        jp_prev = jp;
        repeat (4) @(posedge clk_sys);
        cmp_joy <= 1'b1;
        @(posedge clk_sys);
    endtask

    task automatic wait_game_rst_low(input int limit);
        int n;
        n = 0;
        while (game_rst !== 1'b0 && n < limit) begin
            @(negedge clk_sys);
            n++;
        end
        if (game_rst !== 1'b0) begin
            errors++;
            $display("timeout: game_rst still high after %0d cycles", limit);
        end
    endtask

    // edges from the calling edge until game_rst is seen low after being high
    task automatic measure_stretch(output int result);
        int   n;
        logic seen;
        result = -1;
        seen   = 1'b0;
        for (n = 0; n < 400 && result < 0; n++) begin
            @(negedge clk_sys);
            if (game_rst === 1'b1) begin
                seen = 1'b1;
            end else if (seen) begin
                result = n;
            end
        end
        if (result < 0) begin
            errors++;
            $display("timeout: game_rst did not rise and fall within 400 cycles");
        end
    endtask

    initial begin
        seed        = 32'hd05e_b6c9;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        rst         = 1'b1;
        board_joy1  = '0;
        board_joy2  = '0;
        board_joy3  = '0;
        board_joy4  = '0;
        en4way      = 1'b0;
        rot_control = 1'b0;
        key_pause   = 1'b0;
        key_reset   = 1'b0;
        key_service = 1'b0;
        key_gfx     = '0;
        osd_pause   = 1'b0;
        downloading = 1'b0;
        rst_req     = 1'b0;
        cmp_joy     = 1'b0;
        jp_prev     = 1'b0;
        exp_pause   = 1'b0;
        exp_gfx     = 4'hf;
        for (p = 0; p < 4; p++) begin
            held_dir[p] = '0;
        end
        repeat (16) @(posedge clk_sys);
        rst <= 1'b0;
        @(negedge clk_sys);

        check_value("game_pause", 32'(game_pause), 0);
        check_value("gfx_en", 32'(gfx_en), 32'hf);
        check_value("game_service", 32'(game_service), 1);
        check_value("game_rst", 32'(game_rst), 1);
        end_test("reset state");

        for (i = 0; i < 40; i++) begin
            apply_vector({$random(seed), $random(seed)}, i[0], 1'b0);
        end
        end_test("random words");

        apply_vector(64'h0, 1'b0, 1'b1);   // clear diagonals before four-way
        for (i = 0; i < 8; i++) begin
            words = {$random(seed), $random(seed)};
            for (p = 0; p < 4; p++) begin
                words[16*p +: 4] = 4'b0001 << ((i + p) % 4);
            end
            apply_vector(words, i[0], 1'b1);
            for (p = 0; p < 4; p++) begin
                words[16*p +: 4] |= 4'b0001 << ((i + p + 1) % 4);   // diagonal
            end
            apply_vector(words, i[0], 1'b1);
        end
        apply_vector(64'h0, 1'b0, 1'b0);
        @(posedge clk_sys);
        cmp_joy <= 1'b0;
        end_test("four-way");

        for (i = 0; i < 4; i++) begin
            @(posedge clk_sys);
            case (i)
                0: key_pause <= 1'b1;
                1: board_joy2 <= 16'h0001 << PAUSE_BIT;
                2: key_pause <= ~exp_pause;   // pause on before the download step
                default: downloading <= 1'b1;
            endcase
            if (i == 3) begin
                exp_pause = 1'b0;
            end else if (i == 2) begin
                exp_pause = 1'b1;
            end else begin
                exp_pause = ~exp_pause;
            end
            repeat (3) @(posedge clk_sys);
            key_pause   <= 1'b0;
            board_joy2  <= '0;
            downloading <= 1'b0;
            @(negedge clk_sys);
            check_value("game_pause", 32'(game_pause), 32'(exp_pause));
        end
        end_test("pause");

        for (i = 0; i < 4; i++) begin
            @(posedge clk_sys);
            key_gfx    <= 4'b0001 << i;
            exp_gfx[i] = ~exp_gfx[i];
            repeat (3) @(posedge clk_sys);
            key_gfx <= '0;
            @(negedge clk_sys);
            check_value("gfx_en", 32'(gfx_en), 32'(exp_gfx));
        end
        @(posedge clk_sys);
        key_service <= 1'b1;
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("game_service", 32'(game_service), 32'(1'b1 ^ ACTIVE_LOW));
        end_test("graphics and service");

        wait_game_rst_low(600);
        @(posedge clk_sys);
        key_reset <= 1'b1;
        measure_stretch(cycles);
        check_value("game_rst stretch after key_reset", cycles - 1, 257);   // from first sample
        @(posedge clk_sys);
        key_reset <= 1'b0;
        rst_req   <= 1'b1;
        repeat (3) @(posedge clk_sys);
        rst_req <= 1'b0;
        measure_stretch(cycles);
        check_value("game_rst stretch after rst_req", cycles, 256);
        end_test("game reset");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+bench
hdl/board_pkg.sv
hdl/joy_4way.sv
hdl/joy_capture.sv
hdl/joy_mapper.sv
hdl/board_control.sv
hdl/reset_gen.sv
hdl/board_top.sv
bench/board_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module board_tb

output=$(./obj_dir/Vboard_tb || true)
echo "$output"

# pass only if the testbench printed its pass line
echo "$output" | grep -qx "Finished with no errors"
